//--- common/chip_test_params.svh
`ifndef CHIP_TEST_PARAMS_SVH
`define CHIP_TEST_PARAMS_SVH

////////////////////////////////////////////////////////////////////////////
// frame memory geometry
////////////////////////////////////////////////////////////////////////////
`define FRAME_WIDTH        320   // pixels per row
`define FRAME_HEIGHT       240   // rows per frame
`define COL_BITS           9
`define ROW_BITS           8
`define PIXEL_ADDR_BITS    17    // row * width + col

////////////////////////////////////////////////////////////////////////////
// region table
////////////////////////////////////////////////////////////////////////////
`define REGION_DEPTH       16
`define REGION_INDEX_BITS  4
`define COORD_BITS         9
`define OBJ_COUNT_BITS     5

////////////////////////////////////////////////////////////////////////////
// scan chain
////////////////////////////////////////////////////////////////////////////
`define SCAN_CONFIG_BITS   16
`define SCAN_ADDR_BITS     7
`define SCAN_LOAD_BITS     23    // config word above address
`define SCAN_MARKER_BITS   24
`define SCAN_READ_CYCLES   31    // config + 2 * addr + 1
`define SCAN_RESULT_BITS   16

`endif

//--- common/chip_test_pkg.sv
`include "chip_test_params.svh"

package chip_test_pkg;

    // one write beat into a frame plane
    typedef struct packed {
        logic valid;
        logic pixel;
    } pixel_write_t;

    typedef struct packed {
        logic [`ROW_BITS-1:0] row;
        logic [`COL_BITS-1:0] col;
    } frame_addr_t;

    typedef struct packed {
        logic                   valid;
        logic [`COORD_BITS-1:0] coord;
    } region_write_t;

    typedef struct packed {
        logic                          valid;
        logic [`REGION_INDEX_BITS-1:0] index;
    } region_read_t;

    typedef struct packed {
        logic [`COORD_BITS-1:0] x;
        logic [`COORD_BITS-1:0] y;
    } region_entry_t;

    typedef enum logic [1:0] {
        SCAN_IDLE    = 2'd0,
        SCAN_LOAD    = 2'd1,
        SCAN_CAPTURE = 2'd2
    } scan_cmd_e;

    typedef enum logic [1:0] {
        RGN_IDLE   = 2'd0,
        RGN_STREAM = 2'd1,
        RGN_HOLD   = 2'd2
    } region_state_e;

    typedef enum logic [1:0] {
        RES_IDLE      = 2'd0,
        RES_WAIT_HOST = 2'd1,
        RES_RELEASE   = 2'd2
    } result_state_e;

endpackage

//--- frame_store/frame_store.sv
`timescale 1ns/1ps
`include "chip_test_params.svh"

module frame_store
    import chip_test_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  pixel_write_t pos_write,
    input  pixel_write_t neg_write,
    input  frame_addr_t  read_addr,
    output logic         pixel_pos,
    output logic         pixel_neg
);

    pixel_write_t                plane_write [2];   // 0 = pos, 1 = neg
    logic                        plane_q     [2];
    logic                        plane_block [2];
    logic                        any_valid;
    logic [`PIXEL_ADDR_BITS-1:0] rd_addr;

    function automatic logic [`PIXEL_ADDR_BITS-1:0] linear_addr(
        input logic [`ROW_BITS-1:0] row,
        input logic [`COL_BITS-1:0] col
    );
        logic [`PIXEL_ADDR_BITS-1:0] r;
        logic [`PIXEL_ADDR_BITS-1:0] c;
        r = `PIXEL_ADDR_BITS'(row);
        c = `PIXEL_ADDR_BITS'(col);
        return r * `PIXEL_ADDR_BITS'(`FRAME_WIDTH) + c;
    endfunction

    assign plane_write[0] = pos_write;
    assign plane_write[1] = neg_write;
    assign plane_block[0] = 1'b0;
    assign plane_block[1] = pos_write.valid;    // pos owns a shared cycle

    assign any_valid = pos_write.valid | neg_write.valid;
    assign rd_addr   = linear_addr(read_addr.row, read_addr.col);

    for (genvar p = 0; p < 2; p++) begin : gen_plane
        logic                        mem [0:`FRAME_WIDTH*`FRAME_HEIGHT-1];
        logic [`ROW_BITS-1:0]        wr_row;
        logic [`COL_BITS-1:0]        wr_col;
        logic                        we;
        logic [`PIXEL_ADDR_BITS-1:0] addr;

        assign we = plane_write[p].valid && !plane_block[p]
                    && (wr_row < `ROW_BITS'(`FRAME_HEIGHT));

        // write takes the port over the chip read
        assign addr = we ? linear_addr(wr_row, wr_col) : rd_addr;

        ////////////////////////////////////////////////////////////////////////
        // raster counter, column first
        ////////////////////////////////////////////////////////////////////////
        always_ff @(posedge clk or posedge reset) begin
            if (reset) begin
                wr_row <= '0;
                wr_col <= '0;
            end else if (!any_valid) begin
                wr_row <= '0;   // gap ends the stream
                wr_col <= '0;
            end else if (we) begin
                if (wr_col == `COL_BITS'(`FRAME_WIDTH - 1)) begin
                    wr_col <= '0;
                    wr_row <= wr_row + 1'b1;
                end else begin
                    wr_col <= wr_col + 1'b1;
                end
            end
        end

        always_ff @(posedge clk) begin
            if (we)
                mem[addr] <= plane_write[p].pixel;
        end

        always_ff @(posedge clk or posedge reset) begin
            if (reset)
                plane_q[p] <= 1'b0;
            else
                plane_q[p] <= mem[addr];
        end
    end

    assign pixel_pos = plane_q[0];
    assign pixel_neg = plane_q[1];

endmodule

//--- scan_chain/scan_chain.sv
`timescale 1ns/1ps
`include "chip_test_params.svh"

module scan_chain
    import chip_test_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  scan_cmd_e                     scan_cmd,
    input  logic [`SCAN_CONFIG_BITS-1:0]  scan_config,
    input  logic [`SCAN_ADDR_BITS-1:0]    scan_addr,
    input  logic                          serial_in,
    output logic                          serial_out,
    output logic                          update_strobe,
    output logic                          capture_strobe,
    output logic [`SCAN_RESULT_BITS-1:0]  scan_result
);

    logic [`SCAN_LOAD_BITS-1:0]   load_shift;
    logic [`SCAN_MARKER_BITS-1:0] update_marker;
    logic [`SCAN_MARKER_BITS-1:0] capture_marker;
    logic [`SCAN_MARKER_BITS-1:0] marker_init;
    logic [`SCAN_MARKER_BITS-1:0] readback;     // serial_in enters at the top
    logic [4:0]                   read_count;

    assign marker_init    = {1'b1, {(`SCAN_MARKER_BITS-1){1'b0}}};
    assign serial_out     = load_shift[0];      // lsb first
    assign update_strobe  = update_marker[0];
    assign capture_strobe = capture_marker[0];

    ////////////////////////////////////////////////////////////////////////////
    // load shifter and strobe markers
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_shift     <= '0;
            update_marker  <= '0;
            capture_marker <= '0;
        end else begin
            case (scan_cmd)
                SCAN_LOAD: begin
                    load_shift     <= {scan_config, scan_addr};
                    update_marker  <= marker_init;
                    capture_marker <= '0;
                end
                SCAN_CAPTURE: begin
                    // address only, config field zero
                    load_shift     <= {{`SCAN_CONFIG_BITS{1'b0}}, scan_addr};
                    update_marker  <= '0;
                    capture_marker <= marker_init;
                end
                default: begin
                    load_shift     <= load_shift >> 1;
                    update_marker  <= update_marker >> 1;
                    capture_marker <= capture_marker >> 1;
                end
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // readback deserializer
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            readback    <= '0;
            read_count  <= 5'(`SCAN_READ_CYCLES);   // idle until first capture
            scan_result <= '0;
        end else if (capture_strobe) begin
            readback   <= '0;
            read_count <= '0;
        end else if (read_count < 5'(`SCAN_READ_CYCLES)) begin
            readback   <= {serial_in, readback[`SCAN_MARKER_BITS-1:1]};
            read_count <= read_count + 1'b1;
        end else begin
            scan_result <= readback[`SCAN_RESULT_BITS-1:0];  // held until next capture
        end
    end

endmodule

//--- source/region_table.sv
`timescale 1ns/1ps
`include "chip_test_params.svh"

module region_table
    import chip_test_pkg::*;
(
    input  logic          clk,
    input  logic          reset,
    input  region_write_t region_x_write,
    input  region_write_t region_y_write,
    input  region_read_t  region_read,
    output region_entry_t region_out,
    output logic          region_valid
);

    region_write_t          tbl_write [2];   // 0 = x, 1 = y
    logic [`COORD_BITS-1:0] coord_q   [2];

    assign tbl_write[0] = region_x_write;
    assign tbl_write[1] = region_y_write;

    for (genvar t = 0; t < 2; t++) begin : gen_table
        logic [`COORD_BITS-1:0]        mem [0:`REGION_DEPTH-1];
        logic [`REGION_INDEX_BITS-1:0] wr_ptr;

        // pointer wraps at 16, only reset rewinds it
        always_ff @(posedge clk or posedge reset) begin
            if (reset)
                wr_ptr <= '0;
            else if (tbl_write[t].valid)
                wr_ptr <= wr_ptr + 1'b1;
        end

        always_ff @(posedge clk) begin
            if (tbl_write[t].valid)
                mem[wr_ptr] <= tbl_write[t].coord;
            if (region_read.valid)
                coord_q[t] <= mem[region_read.index];
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset)
            region_valid <= 1'b0;
        else
            region_valid <= region_read.valid;  // lines up with coord_q
    end

    assign region_out.x = coord_q[0];
    assign region_out.y = coord_q[1];

endmodule

//--- source/test_sequencer.sv
`timescale 1ns/1ps
`include "chip_test_params.svh"

module test_sequencer
    import chip_test_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic [`OBJ_COUNT_BITS-1:0]  num_obj,
    input  logic                        region_enable,
    output region_read_t                region_read,
    input  logic                        cnn_done,
    input  logic                        host_read_done,
    input  logic                        cnn_ready,
    output logic                        result_ready,
    output logic                        cnn_rd_done,
    input  logic                        scan_load,
    input  logic                        scan_capture,
    output scan_cmd_e                   scan_cmd
);

    region_state_e                 rgn_state;
    logic [`REGION_INDEX_BITS-1:0] rgn_index;
    logic [`REGION_INDEX_BITS-1:0] rgn_last;     // last index of this stream
    logic [`OBJ_COUNT_BITS-1:0]    obj_clamped;
    result_state_e                 res_state;

    ////////////////////////////////////////////////////////////////////////////
    // region streaming
    ////////////////////////////////////////////////////////////////////////////
    always_comb begin
        obj_clamped = num_obj;
        if (num_obj > `OBJ_COUNT_BITS'(`REGION_DEPTH))
            obj_clamped = `OBJ_COUNT_BITS'(`REGION_DEPTH);
    end

    // request goes away in the same cycle enable drops
    assign region_read.valid = (rgn_state == RGN_STREAM) && region_enable;
    assign region_read.index = rgn_index;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rgn_state <= RGN_IDLE;
            rgn_index <= '0;
            rgn_last  <= '0;
        end else begin
            case (rgn_state)
                RGN_IDLE: begin
                    rgn_index <= '0;
                    rgn_last  <= `REGION_INDEX_BITS'(obj_clamped - 1'b1);
                    if (region_enable)
                        rgn_state <= (obj_clamped == '0) ? RGN_HOLD : RGN_STREAM;
                end
                RGN_STREAM: begin
                    rgn_index <= rgn_index + 1'b1;
                    if (!region_enable)
                        rgn_state <= RGN_IDLE;
                    else if (rgn_index == rgn_last)
                        rgn_state <= RGN_HOLD;
                end
                RGN_HOLD: if (!region_enable) rgn_state <= RGN_IDLE;
                default:  rgn_state <= RGN_IDLE;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // cnn result handshake, read-done echo
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            res_state    <= RES_IDLE;
            result_ready <= 1'b0;
            cnn_rd_done  <= 1'b0;
        end else begin
            cnn_rd_done  <= cnn_ready;
            result_ready <= 1'b0;   // single cycle pulse
            case (res_state)
                RES_IDLE: begin
                    if (cnn_done) begin
                        result_ready <= 1'b1;
                        res_state    <= RES_WAIT_HOST;
                    end
                end
                RES_WAIT_HOST: if (host_read_done) res_state <= RES_RELEASE;
                default:       res_state <= RES_IDLE;
            endcase
        end
    end

    // load beats capture when both arrive
    always_comb begin
        if (scan_load)
            scan_cmd = SCAN_LOAD;
        else if (scan_capture)
            scan_cmd = SCAN_CAPTURE;
        else
            scan_cmd = SCAN_IDLE;
    end

endmodule

//--- source/chip_test_top.sv
`timescale 1ns/1ps
`include "chip_test_params.svh"

module chip_test_top
    import chip_test_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    // frame store
    input  pixel_write_t                  pos_write,
    input  pixel_write_t                  neg_write,
    input  frame_addr_t                   read_addr,
    output logic                          pixel_pos,
    output logic                          pixel_neg,
    // region table
    input  region_write_t                 region_x_write,
    input  region_write_t                 region_y_write,
    input  logic [`OBJ_COUNT_BITS-1:0]    num_obj,
    input  logic                          region_enable,
    output region_entry_t                 region_out,
    output logic                          region_valid,
    // cnn result handshake
    input  logic                          cnn_done,
    input  logic                          host_read_done,
    input  logic                          cnn_ready,
    output logic                          result_ready,
    output logic                          cnn_rd_done,
    // scan chain
    input  logic                          scan_load,
    input  logic                          scan_capture,
    input  logic [`SCAN_CONFIG_BITS-1:0]  scan_config,
    input  logic [`SCAN_ADDR_BITS-1:0]    scan_addr,
    input  logic                          serial_in,
    output logic                          serial_out,
    output logic                          update_strobe,
    output logic                          capture_strobe,
    output logic [`SCAN_RESULT_BITS-1:0]  scan_result
);

    region_read_t region_read;  // sequencer -> table
    scan_cmd_e    scan_cmd;

    test_sequencer u_sequencer (
        .clk            (clk),
        .reset          (reset),
        .num_obj        (num_obj),
        .region_enable  (region_enable),
        .region_read    (region_read),
        .cnn_done       (cnn_done),
        .host_read_done (host_read_done),
        .cnn_ready      (cnn_ready),
        .result_ready   (result_ready),
        .cnn_rd_done    (cnn_rd_done),
        .scan_load      (scan_load),
        .scan_capture   (scan_capture),
        .scan_cmd       (scan_cmd)
    );

    frame_store u_frame_store (
        .clk       (clk),
        .reset     (reset),
        .pos_write (pos_write),
        .neg_write (neg_write),
        .read_addr (read_addr),
        .pixel_pos (pixel_pos),
        .pixel_neg (pixel_neg)
    );

    region_table u_region_table (
        .clk            (clk),
        .reset          (reset),
        .region_x_write (region_x_write),
        .region_y_write (region_y_write),
        .region_read    (region_read),
        .region_out     (region_out),
        .region_valid   (region_valid)
    );

    scan_chain u_scan_chain (
        .clk            (clk),
        .reset          (reset),
        .scan_cmd       (scan_cmd),
        .scan_config    (scan_config),
        .scan_addr      (scan_addr),
        .serial_in      (serial_in),
        .serial_out     (serial_out),
        .update_strobe  (update_strobe),
        .capture_strobe (capture_strobe),
        .scan_result    (scan_result)
    );

endmodule

//--- verification/chip_test_tb.sv
`timescale 1ns/1ps
`include "chip_test_params.svh"

module chip_test_tb
    import chip_test_pkg::*;
();

    localparam int FRAME_PIXELS = `FRAME_WIDTH * `FRAME_HEIGHT;
    localparam int CYCLE_BUDGET = 2 * FRAME_PIXELS + 1000;   // two frame loads dominate

    logic                          clk;
    logic                          reset;
    pixel_write_t                  pos_write;
    pixel_write_t                  neg_write;
    frame_addr_t                   read_addr;
    logic                          pixel_pos;
    logic                          pixel_neg;
    region_write_t                 region_x_write;
    region_write_t                 region_y_write;
    logic [`OBJ_COUNT_BITS-1:0]    num_obj;
    logic                          region_enable;
    region_entry_t                 region_out;
    logic                          region_valid;
    logic                          cnn_done;
    logic                          host_read_done;
    logic                          cnn_ready;
    logic                          result_ready;
    logic                          cnn_rd_done;
    logic                          scan_load;
    logic                          scan_capture;
    logic [`SCAN_CONFIG_BITS-1:0]  scan_config;
    logic [`SCAN_ADDR_BITS-1:0]    scan_addr;
    logic                          serial_in;
    logic                          serial_out;
    logic                          update_strobe;
    logic                          capture_strobe;
    logic [`SCAN_RESULT_BITS-1:0]  scan_result;

    logic [31:0]            rng_state = 32'hd8af_31f0;
    string                  test_name = "startup";
    int                     errors = 0;
    int                     errors_at_start = 0;
    int                     tests_passed = 0;
    int                     tests_failed = 0;
    int                     pos_at = 0;     // model raster positions
    int                     neg_at = 0;
    logic                   ready_prev = 1'b0;  // cnn_ready at the previous edge
    logic                   pos_model [FRAME_PIXELS];
    logic                   neg_model [FRAME_PIXELS];
    logic [`COORD_BITS-1:0] x_model   [`REGION_DEPTH];
    logic [`COORD_BITS-1:0] y_model   [`REGION_DEPTH];

    chip_test_top UUT (.*);

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    initial begin
        repeat (2 * CYCLE_BUDGET) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles", 2 * CYCLE_BUDGET);
        $display("TESTBENCH FAILED");
        $finish;
    end

    ////////////////////////////////////////////////////////////////////////////
    // always-on checks
    ////////////////////////////////////////////////////////////////////////////
    always @(posedge clk)
        ready_prev <= cnn_ready;

    echo_check: assert property (@(posedge clk) disable iff (reset)
        cnn_rd_done == ready_prev)
    else begin
        $display("[FAIL] %s: cnn_rd_done expected 0x%0h actual 0x%0h",
                 test_name, $sampled(ready_prev), $sampled(cnn_rd_done));
        errors++;
    end

    ready_width_check: assert property (@(posedge clk) disable iff (reset)
        result_ready |=> !result_ready)
    else begin
        $display("[FAIL] %s: result_ready after a pulse expected 0x0 actual 0x%0h",
                 test_name, $sampled(result_ready));
        errors++;
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] v;
        v = s ^ (s << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    function automatic logic [31:0] next_random();
        rng_state = xorshift32(rng_state);
        return rng_state;
    endfunction

    task automatic step();
        @(posedge clk);
        #1;     // drive point after the edge
    endtask

    task automatic expect_eq(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
        assert (actual === expected)
        else begin
            $display("[FAIL] %s: %s expected 0x%0h actual 0x%0h",
                     test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name       = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: passed", test_name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d error(s)", test_name, errors - errors_at_start);
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // frame store model and stimulus
    ////////////////////////////////////////////////////////////////////////////
    // pos owns a shared cycle, neg only writes alone
    task automatic drive_beat(input bit on_pos, input bit on_neg);
        logic [31:0] r;
        r = next_random();
        pos_write.valid = on_pos;
        pos_write.pixel = r[0];
        neg_write.valid = on_neg;
        neg_write.pixel = r[1];
        if (on_pos) begin
            if (pos_at < FRAME_PIXELS)
                pos_model[pos_at] = r[0];
            pos_at++;
        end else if (on_neg) begin
            if (neg_at < FRAME_PIXELS)
                neg_model[neg_at] = r[1];
            neg_at++;
        end
        step();
    endtask

    task automatic idle_cycle();
        pos_write = '0;
        neg_write = '0;
        pos_at    = 0;  // a gap rewinds both streams
        neg_at    = 0;
        step();
    endtask

    task automatic check_pixel(input int row, input int col);
        int a;
        a = row * `FRAME_WIDTH + col;
        read_addr.row = `ROW_BITS'(row);
        read_addr.col = `COL_BITS'(col);
        step();
        expect_eq("pixel_pos", 32'(pos_model[a]), 32'(pixel_pos));
        expect_eq("pixel_neg", 32'(neg_model[a]), 32'(pixel_neg));
    endtask

    task automatic frame_readback_test();
        logic [31:0] r;
        begin_test("frame plane readback");
        for (int i = 0; i < FRAME_PIXELS; i++)
            drive_beat(1'b1, 1'b0);
        idle_cycle();
        for (int i = 0; i < FRAME_PIXELS; i++)
            drive_beat(1'b0, 1'b1);
        idle_cycle();
        for (int n = 0; n < 200; n++) begin
            r = next_random();
            check_pixel(int'(r[15:0]) % `FRAME_HEIGHT, int'(r[31:16]) % `FRAME_WIDTH);
        end
        finish_test();
    endtask

    task automatic raster_restart_test();
        begin_test("raster restart and priority");
        repeat (20) drive_beat(1'b1, 1'b0);
        idle_cycle();
        repeat (10) drive_beat(1'b1, 1'b0);   // must land from (0,0) again
        idle_cycle();
        repeat (8) drive_beat(1'b1, 1'b1);    // neg held back
        repeat (4) drive_beat(1'b0, 1'b1);
        idle_cycle();
        for (int c = 0; c < 20; c++)
            check_pixel(0, c);
        finish_test();
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // region table, handshake, scan chain
    ////////////////////////////////////////////////////////////////////////////
    task automatic stream_regions(input int count, input int expected);
        int seen;
        seen          = 0;
        num_obj       = `OBJ_COUNT_BITS'(count);
        region_enable = 1'b1;
        repeat (expected + 12) begin
            step();
            if (region_valid) begin
                if (seen < `REGION_DEPTH)
                    expect_eq("region_out", 32'({x_model[seen], y_model[seen]}),
                              32'(region_out));
                seen++;
            end
        end
        expect_eq("region_valid cycles", expected, seen);
        region_enable = 1'b0;
        step();
        step();
    endtask

    task automatic region_stream_test();
        logic [31:0] r;
        begin_test("region streaming");
        for (int i = 0; i < `REGION_DEPTH; i++) begin
            r = next_random();
            x_model[i] = r[8:0];
            y_model[i] = r[24:16];
            region_x_write.valid = 1'b1;
            region_x_write.coord = r[8:0];
            region_y_write.valid = 1'b1;
            region_y_write.coord = r[24:16];
            step();
        end
        region_x_write = '0;
        region_y_write = '0;
        stream_regions(5, 5);
        stream_regions(20, `REGION_DEPTH);  // clamped
        finish_test();
    endtask

    task automatic step_with_ready();
        logic [31:0] r;
        r         = next_random();
        cnn_ready = r[0];
        step();
    endtask

    task automatic handshake_test();
        int pulses;
        begin_test("result handshake and read-done echo");
        pulses   = 0;
        cnn_done = 1'b1;
        repeat (8) begin
            step_with_ready();
            if (result_ready)
                pulses++;
        end
        expect_eq("result_ready pulses", 1, pulses);
        host_read_done = 1'b1;
        step_with_ready();
        host_read_done = 1'b0;
        expect_eq("result_ready in release", 0, 32'(result_ready));
        step_with_ready();
        expect_eq("result_ready back in idle", 0, 32'(result_ready));
        step_with_ready();
        expect_eq("result_ready on held done", 1, 32'(result_ready));
        cnn_done       = 1'b0;
        host_read_done = 1'b1;
        step_with_ready();
        host_read_done = 1'b0;
        repeat (4) step_with_ready();
        finish_test();
    endtask

    task automatic run_load(input bit with_capture);
        logic [31:0]                r;
        logic [`SCAN_LOAD_BITS-1:0] word;
        r            = next_random();
        word         = {r[15:0], r[22:16]};  // config above address
        scan_config  = r[15:0];
        scan_addr    = r[22:16];
        scan_load    = 1'b1;
        scan_capture = with_capture;
        step();
        scan_load    = 1'b0;
        scan_capture = 1'b0;
        for (int k = 0; k < 30; k++) begin
            if (k < `SCAN_LOAD_BITS)
                expect_eq("serial_out", 32'(word[k]), 32'(serial_out));
            expect_eq("update_strobe", 32'(k == `SCAN_LOAD_BITS), 32'(update_strobe));
            expect_eq("capture_strobe", 0, 32'(capture_strobe));
            step();
        end
    endtask

    task automatic scan_load_test();
        begin_test("scan load");
        run_load(1'b0);
        run_load(1'b1);
        finish_test();
    endtask

    task automatic scan_capture_test();
        logic [31:0] r;
        logic [63:0] serial_bits;   // bit k driven k cycles after the command edge
        begin_test("scan capture readback");
        r            = next_random();
        scan_addr    = r[6:0];
        scan_capture = 1'b1;
        step();
        scan_capture = 1'b0;
        for (int k = 0; k < 64; k++) begin
            expect_eq("capture_strobe", 32'(k == `SCAN_LOAD_BITS), 32'(capture_strobe));
            r              = next_random();
            serial_in      = r[0];
            serial_bits[k] = r[0];
            step();
        end
        // edges 8..23 after the strobe sample the bits driven at 31..46
        expect_eq("scan_result", 32'(serial_bits[46:31]), 32'(scan_result));
        finish_test();
    endtask

    initial begin
        reset          = 1'b1;
        pos_write      = '0;
        neg_write      = '0;
        read_addr      = '0;
        region_x_write = '0;
        region_y_write = '0;
        num_obj        = '0;
        region_enable  = 1'b0;
        cnn_done       = 1'b0;
        host_read_done = 1'b0;
        cnn_ready      = 1'b0;
        scan_load      = 1'b0;
        scan_capture   = 1'b0;
        scan_config    = '0;
        scan_addr      = '0;
        serial_in      = 1'b0;
        repeat (16) @(posedge clk);
        #1;
        begin_test("reset values");
        expect_eq("outputs in reset", 0,
                  32'({result_ready, region_valid, update_strobe, capture_strobe,
                       serial_out, cnn_rd_done, pixel_pos, pixel_neg, scan_result}));
        reset = 1'b0;
        finish_test();
        step();

        frame_readback_test();
        raster_restart_test();
        region_stream_test();
        handshake_test();
        scan_load_test();
        scan_capture_test();

        $display("tests passed: %0d, tests failed: %0d, errors: %0d",
                 tests_passed, tests_failed, errors);
        if (tests_failed == 0 && errors == 0)
            $display("TESTBENCH PASSED");
        else
            $display("TESTBENCH FAILED");
        $finish;
    end

endmodule

//--- list.f
+incdir+common
common/chip_test_pkg.sv
frame_store/frame_store.sv
scan_chain/scan_chain.sv
source/region_table.sv
source/test_sequencer.sv
source/chip_test_top.sv
verification/chip_test_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the chip test harness simulation with Verilator.
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f list.f --top-module chip_test_tb \
    --Mdir obj_dir -o chip_test_sim

./obj_dir/chip_test_sim | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
    echo "simulation reported failure"
    exit 1
fi

if ! grep -q "TESTBENCH PASSED" sim.log; then
    echo "simulation ended without a result"
    exit 1
fi

echo "simulation passed"
